// ==== common/div_cfg_pkg.sv ====
`default_nettype none

package div_cfg_pkg;

  // divider lanes working side by side
  localparam int NUM_DIV = 2;

  // element width for SEW 32
  localparam int XLEN = 32;

  // destination tag handed back to the reorder buffer
  localparam int TAG_W = 5;

  // reservation-station entries
  localparam int RS_DEPTH = 8;

  // pointer width into the entry array
  localparam int RS_PTR_W = 3;

  // occupancy must reach RS_DEPTH itself
  localparam int RS_CNT_W = 4;

endpackage

`default_nettype wire

// ==== common/div_op_pkg.sv ====
`default_nettype none

package div_op_pkg;

  import div_cfg_pkg::*;

  localparam int OP_W = 2;

  // operation encodings
  localparam logic [OP_W-1:0] OP_DIVU = 2'b00;
  localparam logic [OP_W-1:0] OP_DIV  = 2'b01;
  localparam logic [OP_W-1:0] OP_REMU = 2'b10;
  localparam logic [OP_W-1:0] OP_REM  = 2'b11;

  // micro-op fields from low to high are dividend, divisor, operation and tag
  localparam int UOP_SRC1_LSB = 0;
  localparam int UOP_SRC2_LSB = UOP_SRC1_LSB + XLEN;
  localparam int UOP_OP_LSB   = UOP_SRC2_LSB + XLEN;
  localparam int UOP_TAG_LSB  = UOP_OP_LSB + OP_W;

  // 71 bits
  localparam int UOP_W = UOP_TAG_LSB + TAG_W;

  // result record is {tag, data}
  localparam int RES_DATA_LSB = 0;
  localparam int RES_TAG_LSB  = RES_DATA_LSB + XLEN;

  // 37 bits
  localparam int RES_W = XLEN + TAG_W;

endpackage

`default_nettype wire

// ==== logic/div_rs_queue.sv ====
`default_nettype none
`timescale 1ns/1ps

module div_rs_queue
  import div_cfg_pkg::*;
  import div_op_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          push,
  input  logic [UOP_W-1:0]              push_uop,
  input  logic [NUM_DIV-1:0]            pop,
  output logic [NUM_DIV-1:0][UOP_W-1:0] head_uop,
  output logic                          empty,
  output logic [NUM_DIV-1:0]            almost_empty,
  output logic                          full
);

  logic [UOP_W-1:0]    mem [RS_DEPTH];
  logic [RS_PTR_W-1:0] wr_ptr;
  logic [RS_PTR_W-1:0] rd_ptr;
  logic [RS_CNT_W-1:0] count;
  logic [RS_CNT_W-1:0] pop_cnt;
  logic                push_en;

  // a push into a full queue is dropped
  assign push_en = push && !full;

  // number of entries popped this edge
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < NUM_DIV; i++) begin
      pop_cnt = pop_cnt + RS_CNT_W'(pop[i]);
    end
  end

  // oldest entries read straight from the array
  always_comb begin
    for (int i = 0; i < NUM_DIV; i++) begin
      head_uop[i] = mem[rd_ptr + RS_PTR_W'(i)];
    end
  end

  // depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + RS_PTR_W'(pop_cnt);
      count  <= count + RS_CNT_W'(push_en) - pop_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (push_en) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  // flags off the registered count
  assign empty = (count == '0);
  assign full  = (count == RS_CNT_W'(RS_DEPTH));

  // bit i set while the queue holds i entries or fewer
  for (genvar i = 0; i < NUM_DIV; i++) begin : g_almost_empty
    assign almost_empty[i] = (count <= RS_CNT_W'(i));
  end

endmodule

`default_nettype wire

// ==== div/div_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module div_unit
  import div_cfg_pkg::*;
  import div_op_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             uop_valid,
  input  logic [UOP_W-1:0] uop,
  output logic             result_valid,
  output logic [RES_W-1:0] result,
  input  logic             result_ready
);

  // micro-op fields
  logic [XLEN-1:0]  src1;
  logic [XLEN-1:0]  src2;
  logic [OP_W-1:0]  op;
  logic [TAG_W-1:0] tag;

  logic             op_signed;
  logic             op_rem;
  logic             a_neg;
  logic             b_neg;
  logic [XLEN-1:0]  abs_a;
  logic [XLEN-1:0]  abs_b;
  logic             div_zero;
  logic             sign_ovf;
  logic             special;
  logic [XLEN-1:0]  special_data;

  // fsm is idle when neither flag is set
  logic             busy;
  logic             done;
  logic             idle;
  logic [$clog2(XLEN)-1:0] iter_cnt;
  logic             last_iter;

  // datapath held for the whole divide
  logic [XLEN-1:0]  quo;
  logic [XLEN-1:0]  rem;
  logic [XLEN-1:0]  dvs;
  logic             q_neg;
  logic             r_neg;
  logic             sel_rem;
  logic [TAG_W-1:0] tag_q;
  logic [XLEN-1:0]  res_data;

  logic [XLEN:0]    trial;
  logic             ge;
  logic [XLEN-1:0]  quo_next;
  logic [XLEN-1:0]  rem_next;
  logic [XLEN-1:0]  final_data;

  assign src1 = uop[UOP_SRC1_LSB +: XLEN];
  assign src2 = uop[UOP_SRC2_LSB +: XLEN];
  assign op   = uop[UOP_OP_LSB +: OP_W];
  assign tag  = uop[UOP_TAG_LSB +: TAG_W];

  assign op_signed = (op == OP_DIV) || (op == OP_REM);
  assign op_rem    = (op == OP_REMU) || (op == OP_REM);

  // divide on magnitudes and put the signs back at the end
  assign a_neg = op_signed && src1[XLEN-1];
  assign b_neg = op_signed && src2[XLEN-1];
  assign abs_a = a_neg ? -src1 : src1;
  assign abs_b = b_neg ? -src2 : src2;

  // riscv special cases need no iterations
  assign div_zero = (src2 == '0);
  assign sign_ovf = op_signed && (src1 == {1'b1, {(XLEN-1){1'b0}}}) && (&src2);
  assign special  = div_zero || sign_ovf;

  always_comb begin
    if (div_zero) begin
      special_data = op_rem ? src1 : '1;
    end else begin
      special_data = op_rem ? '0 : src1;
    end
  end

  assign idle      = !busy && !done;
  assign last_iter = (int'(iter_cnt) == XLEN - 1);

  // one restoring step shifts in the next dividend bit and tries the subtract
  assign trial    = {rem, quo[XLEN-1]};
  assign ge       = (trial >= {1'b0, dvs});
  assign rem_next = ge ? XLEN'(trial - {1'b0, dvs}) : trial[XLEN-1:0];
  assign quo_next = {quo[XLEN-2:0], ge};

  // sign fix-up folded into the last step
  assign final_data = sel_rem ? (r_neg ? -rem_next : rem_next)
                              : (q_neg ? -quo_next : quo_next);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      iter_cnt <= '0;
    end else if (idle) begin
      if (uop_valid) begin
        busy     <= !special;
        done     <= special;
        iter_cnt <= '0;
      end
    end else if (busy) begin
      iter_cnt <= iter_cnt + 1'b1;
      if (last_iter) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (result_ready) begin
      // handshake frees the lane for the next cycle
      done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (idle && uop_valid) begin
      quo      <= abs_a;
      rem      <= '0;
      dvs      <= abs_b;
      q_neg    <= a_neg ^ b_neg;
      r_neg    <= a_neg;
      sel_rem  <= op_rem;
      tag_q    <= tag;
      res_data <= special_data;
    end else if (busy) begin
      quo <= quo_next;
      rem <= rem_next;
      if (last_iter) begin
        res_data <= final_data;
      end
    end
  end

  assign result_valid                   = done;
  assign result[RES_DATA_LSB +: XLEN]   = res_data;
  assign result[RES_TAG_LSB +: TAG_W]   = tag_q;

endmodule

`default_nettype wire

// ==== div/div_dispatch.sv ====
`default_nettype none
`timescale 1ns/1ps

module div_dispatch
  import div_cfg_pkg::*;
  import div_op_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,

  // reservation station
  input  logic                          empty,
  input  logic [NUM_DIV-1:0]            almost_empty,
  input  logic [NUM_DIV-1:0][UOP_W-1:0] head_uop,
  output logic [NUM_DIV-1:0]            pop,

  // reorder buffer
  input  logic                          rob_ready,
  output logic [NUM_DIV-1:0]            result_valid,
  output logic [NUM_DIV-1:0][RES_W-1:0] result,
  output logic [NUM_DIV-1:0]            result_ready
);

  logic [NUM_DIV-1:0] uop_valid;
  logic               group_done;

  // lane i owns head i while the queue holds more than i entries
  assign uop_valid[0] = !empty;

  for (genvar i = 1; i < NUM_DIV; i++) begin : g_uop_valid
    assign uop_valid[i] = !(|almost_empty[i:0]);
  end

  // Every lane that holds an entry must be finished. Retiring only part of
  // the group would shift the queue under a lane that is still dividing,
  // and the lane below it would pick the same entry up a second time.
  assign group_done = &(result_valid | ~uop_valid);

  // in-order prefix of finished lanes
  for (genvar i = 0; i < NUM_DIV; i++) begin : g_retire
    assign result_ready[i] = rob_ready && group_done && (&result_valid[i:0]);
    assign pop[i]          = result_valid[i] && result_ready[i];
  end

  for (genvar i = 0; i < NUM_DIV; i++) begin : g_lane
    div_unit u_div_unit (
      .clk          (clk),
      .rst          (rst),
      .uop_valid    (uop_valid[i]),
      .uop          (head_uop[i]),
      .result_valid (result_valid[i]),
      .result       (result[i]),
      .result_ready (result_ready[i])
    );
  end

endmodule

`default_nettype wire

// ==== logic/rvv_div_backend.sv ====
`default_nettype none
`timescale 1ns/1ps

module rvv_div_backend
  import div_cfg_pkg::*;
  import div_op_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,

  // micro-op source
  input  logic                          push,
  input  logic [UOP_W-1:0]              push_uop,
  output logic                          full,

  // reorder buffer side
  input  logic                          rob_ready,
  output logic [NUM_DIV-1:0]            result_valid,
  output logic [NUM_DIV-1:0][RES_W-1:0] result,
  output logic [NUM_DIV-1:0]            result_ready
);

  logic                          rs_empty;
  logic [NUM_DIV-1:0]            rs_almost_empty;
  logic [NUM_DIV-1:0][UOP_W-1:0] rs_head_uop;
  logic [NUM_DIV-1:0]            rs_pop;

  div_rs_queue u_div_rs_queue (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_uop     (push_uop),
    .pop          (rs_pop),
    .head_uop     (rs_head_uop),
    .empty        (rs_empty),
    .almost_empty (rs_almost_empty),
    .full         (full)
  );

  div_dispatch u_div_dispatch (
    .clk          (clk),
    .rst          (rst),
    .empty        (rs_empty),
    .almost_empty (rs_almost_empty),
    .head_uop     (rs_head_uop),
    .pop          (rs_pop),
    .rob_ready    (rob_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

endmodule

`default_nettype wire

// ==== verification/rvv_div_backend_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module rvv_div_backend_props
  import div_cfg_pkg::*;
  import div_op_pkg::*;
(
  input logic                          clk,
  input logic                          rst,
  input logic                          push,
  input logic                          full,
  input logic                          rob_ready,
  input logic [NUM_DIV-1:0]            result_valid,
  input logic [NUM_DIV-1:0][RES_W-1:0] result,
  input logic [NUM_DIV-1:0]            result_ready,
  input logic [NUM_DIV-1:0][RES_W-1:0] exp_result
);

  // sticky flag set by any failing check
  logic check_failed = 1'b0;

  logic [RS_CNT_W-1:0] occ;

  // occupancy seen from the ports where each retire pops one entry
  always_ff @(posedge clk) begin
    if (rst) begin
      occ <= '0;
    end else begin
      occ <= occ + RS_CNT_W'(push && !full)
             - RS_CNT_W'($countones(result_valid & result_ready));
    end
  end

  a_reset_clears: assert property (@(posedge clk) rst |=> (result_valid == '0) && !full)
    else begin
      check_failed = 1'b1;
      $error("result_valid or full high right after reset");
    end

  a_full_flag: assert property (@(posedge clk) disable iff (rst)
    full == (occ == RS_CNT_W'(RS_DEPTH)))
    else begin
      check_failed = 1'b1;
      $error("** Error t=%0t full expected %0b actual %0b", $time,
             $sampled(occ == RS_CNT_W'(RS_DEPTH)), $sampled(full));
    end

  a_no_grant_stalled: assert property (@(posedge clk) disable iff (rst)
    !rob_ready |-> (result_ready == '0))
    else begin
      check_failed = 1'b1;
      $error("result_ready granted while rob_ready is low");
    end

  for (genvar i = 0; i < NUM_DIV; i++) begin : g_lane
    a_data: assert property (@(posedge clk) disable iff (rst)
      result_valid[i] && result_ready[i] |-> result[i] == exp_result[i])
      else begin
        check_failed = 1'b1;
        $error("** Error t=%0t result[%0d] expected %h actual %h", $time, i,
               $sampled(exp_result[i]), $sampled(result[i]));
      end

    a_ready_under_valid: assert property (@(posedge clk) disable iff (rst)
      result_ready[i] |-> result_valid[i])
      else begin
        check_failed = 1'b1;
        $error("result_ready on lane %0d without result_valid", i);
      end

    // a stalled result stays put
    a_hold: assert property (@(posedge clk) disable iff (rst)
      result_valid[i] && !rob_ready |=> result_valid[i] && $stable(result[i]))
      else begin
        check_failed = 1'b1;
        $error("lane %0d result dropped or changed while stalled", i);
      end

    if (i > 0) begin : g_prefix
      a_prefix: assert property (@(posedge clk) disable iff (rst)
        result_ready[i] |-> result_ready[i-1])
        else begin
          check_failed = 1'b1;
          $error("lane %0d granted ahead of the lane below it", i);
        end
    end
  end

endmodule

`default_nettype wire

// ==== verification/rvv_div_backend_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module rvv_div_backend_tb
  import div_cfg_pkg::*;
  import div_op_pkg::*;
();

  localparam int PUSH_TIMEOUT  = 300;
  localparam int FILL_LIMIT    = 20;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam int NUM_RANDOM    = 40;
  localparam int STALL_CYCLES  = 60;

  logic                          clk = 1'b0;
  logic                          rst;
  logic                          push;
  logic [UOP_W-1:0]              push_uop;
  logic                          full;
  logic                          rob_ready;
  logic [NUM_DIV-1:0]            result_valid;
  logic [NUM_DIV-1:0][RES_W-1:0] result;
  logic [NUM_DIV-1:0]            result_ready;

  // expected records with the oldest first
  logic [RES_W-1:0]              exp_q[$];
  logic [NUM_DIV-1:0][RES_W-1:0] exp_result = '0;
  int                            retire_cnt = 0;
  integer                        seed;

  rvv_div_backend u_rvv_div_backend (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_uop     (push_uop),
    .full         (full),
    .rob_ready    (rob_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  bind rvv_div_backend rvv_div_backend_props u_props (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .full         (full),
    .rob_ready    (rob_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready),
    .exp_result   (rvv_div_backend_tb.exp_result)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping on the first error");
  endtask

  task automatic step();
    @(posedge clk);
    #0.5;
  endtask

  // riscv M extension results including the zero and overflow cases
  function automatic logic [XLEN-1:0] ref_div(input logic [OP_W-1:0] op,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic                   ovf;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == '1);
    if (op == OP_DIVU) begin
      ref_div = (b == '0) ? '1 : a / b;
    end else if (op == OP_REMU) begin
      ref_div = (b == '0) ? a : a % b;
    end else if (b == '0) begin
      ref_div = (op == OP_DIV) ? '1 : a;
    end else if (ovf) begin
      ref_div = (op == OP_DIV) ? a : '0;
    end else if (op == OP_DIV) begin
      ref_div = sa / sb;
    end else begin
      ref_div = sa % sb;
    end
  endfunction

  task automatic push_one(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input logic [TAG_W-1:0] tag);
    int               waited;
    logic [UOP_W-1:0] uop;
    logic [RES_W-1:0] rec;
    waited = 0;
    while (full) begin
      if (waited > PUSH_TIMEOUT) fail_run("timeout waiting for room in the queue");
      step();
      waited++;
    end
    uop = '0;
    uop[UOP_SRC1_LSB +: XLEN] = a;
    uop[UOP_SRC2_LSB +: XLEN] = b;
    uop[UOP_OP_LSB +: OP_W]   = op;
    uop[UOP_TAG_LSB +: TAG_W] = tag;
    rec = '0;
    rec[RES_DATA_LSB +: XLEN] = ref_div(op, a, b);
    rec[RES_TAG_LSB +: TAG_W] = tag;
    exp_q.push_back(rec);
    push     = 1'b1;
    push_uop = uop;
    step();
    push = 1'b0;
  endtask

  task automatic push_random();
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    rnd = $random(seed);
    a   = $random(seed);
    b   = $random(seed);
    case (rnd[2:0])
      3'd0: b = '0;
      3'd1: begin
        a = 32'h8000_0000;
        b = '1;
      end
      3'd2: b = {28'b0, rnd[15:12]};
      default: b = b;
    endcase
    push_one(rnd[4:3], a, b, rnd[9:5]);
  endtask

  // retires seen here leave the model after the next rising edge
  always @(negedge clk) begin
    if (u_rvv_div_backend.u_props.check_failed) fail_run("a bound assertion failed");
    repeat (retire_cnt) begin
      if (exp_q.size() == 0) fail_run("a result retired that was never pushed");
      else void'(exp_q.pop_front());
    end
    retire_cnt = 0;
    for (int i = 0; i < NUM_DIV; i++) begin
      exp_result[i] = (i < exp_q.size()) ? exp_q[i] : '0;
      if (!rst && result_valid[i] && result_ready[i]) retire_cnt++;
    end
  end

  initial begin
    int          waited;
    logic [31:0] gap;
    seed      = 32'h504;
    rst       = 1'b1;
    push      = 1'b0;
    push_uop  = '0;
    rob_ready = 1'b0;
    repeat (8) @(posedge clk);
    #0.5;
    rst       = 1'b0;
    rob_ready = 1'b1;

    // zero divisor and overflow pair for every operation
    for (int k = 0; k < 4; k++) begin
      push_one(OP_W'(k), 32'h1357_9bdf, '0, TAG_W'(k));
      push_one(OP_W'(k), 32'h8000_0000, '1, TAG_W'(k + 4));
    end
    for (int k = 0; k < NUM_RANDOM; k++) begin
      push_random();
      gap = $random(seed);
      repeat (gap[1:0]) step();
    end

    // stall the reorder buffer until the queue fills
    rob_ready = 1'b0;
    waited    = 0;
    while (!full) begin
      if (waited > FILL_LIMIT) fail_run("full never rose while the reorder buffer stalled");
      push_random();
      waited++;
    end
    repeat (STALL_CYCLES) step();
    rob_ready = 1'b1;

    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > DRAIN_TIMEOUT) fail_run("timeout waiting for results to drain");
      step();
      waited++;
    end
    step();
    if (u_rvv_div_backend.u_props.check_failed) begin
      fail_run("a bound assertion failed");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== rvv_div_backend.f ====
common/div_cfg_pkg.sv
common/div_op_pkg.sv
logic/div_rs_queue.sv
div/div_unit.sv
div/div_dispatch.sv
logic/rvv_div_backend.sv
verification/rvv_div_backend_properties.sv
verification/rvv_div_backend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the divide backend testbench under verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module rvv_div_backend_tb \
  -f rvv_div_backend.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep going past an assertion error so the testbench can end the run itself
./obj_dir/Vrvv_div_backend_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
